//--- src/axis_mux_pkg.sv
// shared definitions for the four-input stream mux
// port count, port select type and frame lock state

package axis_mux_pkg;

    // select field is two bits, so the port count is fixed
    localparam int NUM_PORTS = 4;

    // names one input port
    typedef logic [1:0] port_sel_t;

    // frame lock state of the selector
    typedef enum logic {
        FRAME_IDLE   = 1'b0,
        FRAME_ACTIVE = 1'b1
    } frame_state_e;

endpackage

//--- src/axis_if.sv
// stream link between the frame selector and the output skid register
// source and sink modports

`timescale 1ns/10ps

interface axis_if #(
    parameter int DATA_WIDTH = 8,
    parameter int USER_WIDTH = 1
);
    logic [DATA_WIDTH-1:0] tdata;
    // one-cycle strobe per accepted input word
    logic                  tvalid;
    logic                  tlast;
    logic [USER_WIDTH-1:0] tuser;
    // sink can take a word in the next cycle
    logic                  ready_early;

    modport source (
        output tdata,
        output tvalid,
        output tlast,
        output tuser,
        input  ready_early
    );

    modport sink (
        input  tdata,
        input  tvalid,
        input  tlast,
        input  tuser,
        output ready_early
    );

endinterface

//--- src/axis_frame_select.sv
// frame selector for the stream mux
// locks onto one input per frame, registers per-port ready and muxes the word

`timescale 1ns/10ps

module axis_frame_select #(
    parameter int DATA_WIDTH = 8,
    parameter int USER_WIDTH = 1
) (
    input  logic                    clk,
    input  logic                    rst,
    input  logic [DATA_WIDTH-1:0]   in_tdata  [axis_mux_pkg::NUM_PORTS],
    input  logic                    in_tvalid [axis_mux_pkg::NUM_PORTS],
    output logic                    in_tready [axis_mux_pkg::NUM_PORTS],
    input  logic                    in_tlast  [axis_mux_pkg::NUM_PORTS],
    input  logic [USER_WIDTH-1:0]   in_tuser  [axis_mux_pkg::NUM_PORTS],
    input  logic                    enable,
    input  axis_mux_pkg::port_sel_t select,
    axis_if.source                  m_axis
);
    import axis_mux_pkg::*;

    frame_state_e state_q;
    frame_state_e state_d;
    port_sel_t    sel_q;
    port_sel_t    sel_d;
    logic         ready_d [NUM_PORTS];

    // word currently presented by the locked port
    logic cur_valid;
    logic cur_ready;
    logic cur_last;
    logic cur_xfer;

    // a frame is waiting on the port named by select
    logic start_valid;

    // data mux from the captured port
    always_comb begin
        cur_valid = in_tvalid[sel_q];
        cur_ready = in_tready[sel_q];
        cur_last  = in_tlast[sel_q];
        cur_xfer  = cur_valid & cur_ready;

        m_axis.tdata  = in_tdata[sel_q];
        m_axis.tlast  = cur_last;
        m_axis.tuser  = in_tuser[sel_q];
        m_axis.tvalid = cur_xfer & (state_q == FRAME_ACTIVE);
    end

    always_comb begin
        state_d = state_q;
        sel_d   = sel_q;

        // end of frame once tlast has passed on the locked port
        if (state_q == FRAME_ACTIVE && cur_xfer && cur_last) begin
            state_d = FRAME_IDLE;
        end

        // the tlast word leaving this cycle is not the start of a new frame
        start_valid = in_tvalid[select] & ~(cur_xfer & (select == sel_q));

        // lock a new frame, possibly on the same edge the last one closed
        if (state_d == FRAME_IDLE && enable && start_valid) begin
            state_d = FRAME_ACTIVE;
            sel_d   = select;
        end

        // only the port locked for the next cycle may see ready
        for (int i = 0; i < NUM_PORTS; i++) begin
            ready_d[i] = (port_sel_t'(i) == sel_d) & m_axis.ready_early &
                         (state_d == FRAME_ACTIVE);
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q <= FRAME_IDLE;
            sel_q   <= '0;
            for (int i = 0; i < NUM_PORTS; i++) begin
                in_tready[i] <= 1'b0;
            end
        end else begin
            state_q <= state_d;
            sel_q   <= sel_d;
            for (int i = 0; i < NUM_PORTS; i++) begin
                in_tready[i] <= ready_d[i];
            end
        end
    end

endmodule

//--- src/axis_skid_reg.sv
// output skid register for the stream mux
// output and temp entries, early ready towards the selector

`timescale 1ns/10ps

module axis_skid_reg #(
    parameter int DATA_WIDTH = 8,
    parameter int USER_WIDTH = 1
) (
    input  logic                  clk,
    input  logic                  rst,
    axis_if.sink                  s_axis,
    output logic [DATA_WIDTH-1:0] out_tdata,
    output logic                  out_tvalid,
    input  logic                  out_tready,
    output logic                  out_tlast,
    output logic [USER_WIDTH-1:0] out_tuser
);

    // output entry
    logic [DATA_WIDTH-1:0] out_data_q;
    logic                  out_last_q;
    logic [USER_WIDTH-1:0] out_user_q;
    logic                  out_valid_q;
    logic                  out_valid_d;

    // temp entry, catches the word in flight when the output stalls
    logic [DATA_WIDTH-1:0] temp_data_q;
    logic                  temp_last_q;
    logic [USER_WIDTH-1:0] temp_user_q;
    logic                  temp_valid_q;
    logic                  temp_valid_d;

    logic ready_int_q;

    logic store_in_to_out;
    logic store_in_to_temp;
    logic store_temp_to_out;

    assign out_tdata  = out_data_q;
    assign out_tvalid = out_valid_q;
    assign out_tlast  = out_last_q;
    assign out_tuser  = out_user_q;

    // room next cycle if the output drains, or the temp entry will stay empty
    assign s_axis.ready_early = out_tready |
                                (~temp_valid_q & (~out_valid_q | ~s_axis.tvalid));

    always_comb begin
        out_valid_d       = out_valid_q;
        temp_valid_d      = temp_valid_q;
        store_in_to_out   = 1'b0;
        store_in_to_temp  = 1'b0;
        store_temp_to_out = 1'b0;

        if (ready_int_q) begin
            if (out_tready || !out_valid_q) begin
                // output free or draining
                out_valid_d     = s_axis.tvalid;
                store_in_to_out = 1'b1;
            end else begin
                temp_valid_d     = s_axis.tvalid;
                store_in_to_temp = 1'b1;
            end
        end else if (out_tready) begin
            // no input accepted, move the temp word up
            out_valid_d       = temp_valid_q;
            temp_valid_d      = 1'b0;
            store_temp_to_out = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid_q  <= 1'b0;
            temp_valid_q <= 1'b0;
            ready_int_q  <= 1'b0;
        end else begin
            out_valid_q  <= out_valid_d;
            temp_valid_q <= temp_valid_d;
            ready_int_q  <= s_axis.ready_early;
        end
    end

    always_ff @(posedge clk) begin
        if (store_in_to_out) begin
            out_data_q <= s_axis.tdata;
            out_last_q <= s_axis.tlast;
            out_user_q <= s_axis.tuser;
        end else if (store_temp_to_out) begin
            out_data_q <= temp_data_q;
            out_last_q <= temp_last_q;
            out_user_q <= temp_user_q;
        end

        if (store_in_to_temp) begin
            temp_data_q <= s_axis.tdata;
            temp_last_q <= s_axis.tlast;
            temp_user_q <= s_axis.tuser;
        end
    end

endmodule

//--- src/axis_mux_top.sv
// top level of the four-input stream frame mux
// frame selector feeding the output skid register

`timescale 1ns/10ps

module axis_mux_top #(
    parameter int DATA_WIDTH = 8,
    parameter int USER_WIDTH = 1
) (
    input  logic                    clk,
    input  logic                    rst,

    // stream inputs, indexed by port number
    input  logic [DATA_WIDTH-1:0]   in_tdata  [axis_mux_pkg::NUM_PORTS],
    input  logic                    in_tvalid [axis_mux_pkg::NUM_PORTS],
    output logic                    in_tready [axis_mux_pkg::NUM_PORTS],
    input  logic                    in_tlast  [axis_mux_pkg::NUM_PORTS],
    input  logic [USER_WIDTH-1:0]   in_tuser  [axis_mux_pkg::NUM_PORTS],

    // stream output
    output logic [DATA_WIDTH-1:0]   out_tdata,
    output logic                    out_tvalid,
    input  logic                    out_tready,
    output logic                    out_tlast,
    output logic [USER_WIDTH-1:0]   out_tuser,

    // frame control
    input  logic                    enable,
    input  axis_mux_pkg::port_sel_t select
);

    axis_if #(
        .DATA_WIDTH (DATA_WIDTH),
        .USER_WIDTH (USER_WIDTH)
    ) int_axis ();

    axis_frame_select #(
        .DATA_WIDTH (DATA_WIDTH),
        .USER_WIDTH (USER_WIDTH)
    ) u_frame_select (
        .clk       (clk),
        .rst       (rst),
        .in_tdata  (in_tdata),
        .in_tvalid (in_tvalid),
        .in_tready (in_tready),
        .in_tlast  (in_tlast),
        .in_tuser  (in_tuser),
        .enable    (enable),
        .select    (select),
        .m_axis    (int_axis.source)
    );

    axis_skid_reg #(
        .DATA_WIDTH (DATA_WIDTH),
        .USER_WIDTH (USER_WIDTH)
    ) u_skid_reg (
        .clk        (clk),
        .rst        (rst),
        .s_axis     (int_axis.sink),
        .out_tdata  (out_tdata),
        .out_tvalid (out_tvalid),
        .out_tready (out_tready),
        .out_tlast  (out_tlast),
        .out_tuser  (out_tuser)
    );

endmodule

//--- verification/axis_mux_props.sv
// concurrent checks bound to the stream mux top level
// ready exclusivity, output hold under back-pressure, reset state

`timescale 1ns/10ps

module axis_mux_props #(
    parameter int DATA_WIDTH = 8,
    parameter int USER_WIDTH = 1
) (
    input logic                  clk,
    input logic                  rst,
    input logic                  in_tready [axis_mux_pkg::NUM_PORTS],
    input logic [DATA_WIDTH-1:0] out_tdata,
    input logic                  out_tvalid,
    input logic                  out_tready,
    input logic                  out_tlast,
    input logic [USER_WIDTH-1:0] out_tuser
);
    import axis_mux_pkg::*;

    logic [NUM_PORTS-1:0] ready_vec;

    always_comb begin
        for (int i = 0; i < NUM_PORTS; i++) begin
            ready_vec[i] = in_tready[i];
        end
    end

    // only the locked port may see ready
    ready_exclusive: assert property (@(posedge clk) disable iff (rst) $onehot0(ready_vec))
        else $error("more than one input port has tready high");

    // a stalled output word must not change
    stall_hold: assert property (@(posedge clk) disable iff (rst)
        out_tvalid && !out_tready |=> out_tvalid && $stable(out_tdata) &&
                                      $stable(out_tlast) && $stable(out_tuser))
        else $error("output word changed while out_tready was low");

    reset_state: assert property (@(posedge clk) rst |=> !out_tvalid && ready_vec == '0)
        else $error("tready or out_tvalid high in the cycle after reset");

endmodule

//--- verification/axis_mux_tb.sv
// testbench for the four-input stream frame mux
// random frame generators, reference queue model, checks and watchdog

`timescale 1ns/10ps

module axis_mux_tb;
    import axis_mux_pkg::*;

    localparam int DATA_WIDTH  = 8;
    localparam int USER_WIDTH  = 1;
    localparam int CLK_PERIOD  = 40;
    localparam int NUM_TESTS   = 5;
    localparam int DRAIN_LIMIT = 4000;
    // tests x frames x words x cycles per word x period, doubled as margin
    localparam longint TIMEOUT_NS = 2 * NUM_TESTS * 40 * 8 * 4 * CLK_PERIOD;

    logic                  clk;
    logic                  rst;
    logic [DATA_WIDTH-1:0] in_tdata  [NUM_PORTS];
    logic                  in_tvalid [NUM_PORTS];
    logic                  in_tready [NUM_PORTS];
    logic                  in_tlast  [NUM_PORTS];
    logic [USER_WIDTH-1:0] in_tuser  [NUM_PORTS];
    logic [DATA_WIDTH-1:0] out_tdata;
    logic                  out_tvalid;
    logic                  out_tready;
    logic                  out_tlast;
    logic [USER_WIDTH-1:0] out_tuser;
    logic                  enable;
    port_sel_t             select;

    integer seed;
    string  test_name;
    int     test_errors;
    int     total_errors;
    int     tests_run;
    int     tests_failed;

    // frame generators, one per port
    int   frames_left [NUM_PORTS];
    int   words_left  [NUM_PORTS];
    logic in_xfer     [NUM_PORTS];

    // expected words as {data, last, user}, plus the predicted frame lock
    logic [DATA_WIDTH+USER_WIDTH:0] exp_q [$];
    logic      model_active;
    port_sel_t model_sel;

    // control values applied on the next falling edge
    logic      hold_rst;
    logic      en_cfg;
    logic      rand_sel;
    port_sel_t sel_cfg;
    int        ready_pct;

    axis_mux_top u_axis_mux_top (.*);

    bind axis_mux_top axis_mux_props #(
        .DATA_WIDTH (DATA_WIDTH),
        .USER_WIDTH (USER_WIDTH)
    ) u_props (.*);

    initial clk = 1'b0;
    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic report_mismatch(input string what, input logic [31:0] exp,
                                   input logic [31:0] act);
        test_errors++;
        $display("ERROR %s %s: expected %0h actual %0h", test_name, what, exp, act);
    endtask

    task automatic report_failure(input string msg);
        test_errors++;
        $display("%s: %s", test_name, msg);
    endtask

    // present the next word of port p, opening a new frame when one is due
    task automatic load_word(input int p);
        if (words_left[p] == 0 && frames_left[p] > 0) begin
            frames_left[p]--;
            words_left[p] = 1 + $unsigned($random(seed)) % 8;
        end
        in_tvalid[p] = (words_left[p] > 0);
        in_tdata[p]  = DATA_WIDTH'($random(seed));
        in_tuser[p]  = USER_WIDTH'($random(seed));
        in_tlast[p]  = (words_left[p] == 1);
    endtask

    // one clock: drive on the falling edge, then predict the coming rising edge
    task automatic run_cycle();
        logic [DATA_WIDTH+USER_WIDTH:0] exp_word;
        logic                           start_valid;
        @(negedge clk);
        rst        = hold_rst;
        enable     = en_cfg;
        select     = rand_sel ? port_sel_t'($random(seed)) : sel_cfg;
        out_tready = ($unsigned($random(seed)) % 100) < ready_pct;
        for (int p = 0; p < NUM_PORTS; p++) begin
            if (in_xfer[p]) begin
                words_left[p]--;
            end
            if (in_xfer[p] || !in_tvalid[p]) begin
                load_word(p);
            end
        end
        #1;
        for (int p = 0; p < NUM_PORTS; p++) begin
            if (in_tready[p] === 1'b1 && !(model_active && model_sel == port_sel_t'(p))) begin
                report_failure($sformatf("port %0d has tready high without a frame lock", p));
            end
        end
        // output first, it always carries older words
        if (out_tvalid === 1'b1 && out_tready) begin
            if (exp_q.size() == 0) begin
                report_failure("output word appeared that was never accepted");
            end else begin
                exp_word = exp_q.pop_front();
                if (out_tdata !== exp_word[DATA_WIDTH+USER_WIDTH:USER_WIDTH+1]) begin
                    report_mismatch("tdata", exp_word[DATA_WIDTH+USER_WIDTH:USER_WIDTH+1],
                                    out_tdata);
                end
                if (out_tlast !== exp_word[USER_WIDTH]) begin
                    report_mismatch("tlast", exp_word[USER_WIDTH], out_tlast);
                end
                if (out_tuser !== exp_word[USER_WIDTH-1:0]) begin
                    report_mismatch("tuser", exp_word[USER_WIDTH-1:0], out_tuser);
                end
            end
        end
        for (int p = 0; p < NUM_PORTS; p++) begin
            in_xfer[p] = in_tvalid[p] && (in_tready[p] === 1'b1);
            if (in_xfer[p]) begin
                exp_q.push_back({in_tdata[p], in_tlast[p], in_tuser[p]});
                if (in_tlast[p]) begin
                    model_active = 1'b0;
                end
            end
        end
        // a frame locks on the selected port, also on the edge the last one closes
        start_valid = in_tvalid[select] && !in_xfer[select];
        if (!rst && !model_active && enable && start_valid) begin
            model_active = 1'b1;
            model_sel    = select;
        end
        if (rst) begin
            model_active = 1'b0;
        end
    endtask

    task automatic check_idle();
        if (out_tvalid !== 1'b0) begin
            report_mismatch("out_tvalid", 0, out_tvalid);
        end
        for (int p = 0; p < NUM_PORTS; p++) begin
            if (in_tready[p] !== 1'b0) begin
                report_mismatch($sformatf("in_tready[%0d]", p), 0, in_tready[p]);
            end
        end
    endtask

    function automatic logic traffic_done();
        for (int p = 0; p < NUM_PORTS; p++) begin
            if (frames_left[p] != 0 || words_left[p] != 0) begin
                return 1'b0;
            end
        end
        return exp_q.size() == 0;
    endfunction

    task automatic drain_traffic();
        int cycles;
        cycles = 0;
        while (!traffic_done() && cycles < DRAIN_LIMIT) begin
            run_cycle();
            cycles++;
        end
        if (!traffic_done()) begin
            report_failure($sformatf("traffic did not drain within %0d cycles", DRAIN_LIMIT));
        end
    endtask

    task automatic close_test();
        tests_run++;
        if (test_errors != 0) begin
            tests_failed++;
        end
        $display("test %s finished with %0d errors", test_name, test_errors);
        total_errors += test_errors;
        test_errors = 0;
    endtask

    initial begin
        int port;
        seed = 89218;
        rst = 1'b1;
        enable = 1'b0;
        select = '0;
        out_tready = 1'b0;
        for (int p = 0; p < NUM_PORTS; p++) begin
            in_tdata[p] = '0;
            in_tvalid[p] = 1'b0;
            in_tlast[p] = 1'b0;
            in_tuser[p] = '0;
            frames_left[p] = 0;
            words_left[p] = 0;
            in_xfer[p] = 1'b0;
        end
        model_active = 1'b0;
        model_sel = '0;
        hold_rst = 1'b1;
        en_cfg = 1'b0;
        rand_sel = 1'b0;
        sel_cfg = '0;
        ready_pct = 100;
        test_errors = 0;
        total_errors = 0;
        tests_run = 0;
        tests_failed = 0;

        test_name = "reset_state";
        // reset covers three rising edges, the first one at time 20
        for (int i = 0; i < 2; i++) begin
            run_cycle();
            check_idle();
        end
        hold_rst = 1'b0;
        en_cfg = 1'b1;
        for (int i = 0; i < 10; i++) begin
            run_cycle();
            check_idle();
        end
        close_test();

        test_name = "pass_through";
        for (int p = 0; p < NUM_PORTS; p++) begin
            sel_cfg = port_sel_t'(p);
            frames_left[p] = 1;
            drain_traffic();
        end
        close_test();

        test_name = "select_hold";
        rand_sel = 1'b1;
        for (int p = 0; p < NUM_PORTS; p++) begin
            frames_left[p] = 3;
        end
        drain_traffic();
        rand_sel = 1'b0;
        close_test();

        test_name = "enable_gate";
        en_cfg = 1'b0;
        port = $unsigned($random(seed)) % NUM_PORTS;
        sel_cfg = port_sel_t'(port);
        frames_left[port] = 1;
        for (int i = 0; i < 20; i++) begin
            run_cycle();
            check_idle();
        end
        en_cfg = 1'b1;
        drain_traffic();
        close_test();

        test_name = "random_backpressure";
        ready_pct = 30 + $unsigned($random(seed)) % 60;
        rand_sel = 1'b1;
        for (int i = 0; i < 40; i++) begin
            frames_left[$unsigned($random(seed)) % NUM_PORTS]++;
        end
        drain_traffic();
        close_test();

        $display("tests run %0d, tests failed %0d, errors %0d",
                 tests_run, tests_failed, total_errors);
        if (total_errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

    // watchdog
    initial begin
        #(TIMEOUT_NS);
        $display("run timed out after %0d ns before all tests finished", TIMEOUT_NS);
        $display("Test FAILED");
        $finish;
    end

endmodule

//--- axis_mux.f
src/axis_mux_pkg.sv
src/axis_if.sv
src/axis_frame_select.sv
src/axis_skid_reg.sv
src/axis_mux_top.sv
verification/axis_mux_props.sv
verification/axis_mux_tb.sv
